// ==== compile.f ====
+incdir+rtl
rtl/sifhPkg.sv
rtl/histRam.sv
rtl/histMemArbiter.sv
rtl/histAccumulator.sv
rtl/peakScanner.sv
rtl/algebraicBlock.sv
rtl/windowClassifier.sv
rtl/sifhTop.sv
verif/sifhTb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module sifhTb -o sifhSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sifhSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0

// ==== verif/sifh_trace.txt ====
# S <sample> <flag 1 in, 0 out, -1 no window yet>   G <idle cycles after algebraicReady>
# T <thMinus> <thPlus>
# frame 1 mid-range peak in bin 7
S 112 -1
S 115 -1
S 120 -1
S 127 -1
S 118 -1
S 60 -1
S 200 -1
S 125 -1
G 3
T 108 132
# frame 2 peak in bin 0, edges 108 and 132
S 0 0
S 5 0
S 108 1
S 132 1
S 107 0
S 133 0
S 9 0
S 15 0
G 3
T 0 24
# frame 3 peak in the top bin
S 0 1
S 24 1
S 25 0
S 240 0
S 250 0
S 255 0
S 245 0
S 241 0
G 3
T 231 255
# frame 4 bins 3 and 9 tied
S 231 1
S 255 1
S 48 0
S 150 0
S 50 0
S 155 0
S 60 0
S 159 0
G 3
T 44 68
# frame 5 repeats frame 1
S 112 0
S 115 0
S 120 0
S 127 0
S 118 0
S 60 1
S 200 0
S 125 0
G 3
T 108 132

// ==== verif/sifhTb.sv ====
`timescale 1ns/1ps
`include "sifh_params.svh"

module sifhTb import sifhPkg::*; ();

    // cycles allowed for the clear sweep and for one frame scan
    localparam int SWEEP_TIMEOUT  = 200;
    localparam int WINDOW_TIMEOUT = 500;

    logic        clk;
    logic        reset;
    logic        sampleValid;
    sampleWord_u sample;
    pixVal_t     thMinus;
    pixVal_t     thPlus;
    logic        algebraicReady;
    logic        flagValid;
    logic        inWindow;
    logic        windowValid;

    int      errors;
    int      timeouts;
    int      checks;
    // window captured on the last algebraicReady
    pixVal_t gotMinus;
    pixVal_t gotPlus;
    // samples per bin in the frame under way
    int      binTally [`NBINS];

    sifhTop dut (
        .clk(clk), .reset(reset),
        .sampleValid(sampleValid), .sample(sample),
        .thMinus(thMinus), .thPlus(thPlus), .algebraicReady(algebraicReady),
        .flagValid(flagValid), .inWindow(inWindow), .windowValid(windowValid)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic void reportMismatch(string name, int expVal, int gotVal);
        errors++;
        $display("MISMATCH time=%0t signal=%s expected=%0d got=%0d",
                 $time, name, expVal, gotVal);
    endfunction

    task automatic checkWindow(input pixVal_t expMinus, input pixVal_t expPlus,
                               input pixVal_t actMinus, input pixVal_t actPlus);
        checks++;
        if (actMinus !== expMinus) begin
            reportMismatch("thMinus", int'(expMinus), int'(actMinus));
        end
        if (actPlus !== expPlus) begin
            reportMismatch("thPlus", int'(expPlus), int'(actPlus));
        end
    endtask

    // flag outputs one cycle after the strobe
    task automatic checkFlag(input bit expIn, input bit expValid);
        checks++;
        if (flagValid !== 1'b1) begin
            reportMismatch("flagValid", 1, int'(flagValid));
        end
        if (inWindow !== expIn) begin
            reportMismatch("inWindow", int'(expIn), int'(inWindow));
        end
        if (windowValid !== expValid) begin
            reportMismatch("windowValid", int'(expValid), int'(windowValid));
        end
    endtask

    // one strobe then idle so samples sit 4 cycles apart
    task automatic driveSample(input pixVal_t value, input int expFlag);
        @(negedge clk);
        sample.value = value;
        sampleValid  = 1'b1;
        binTally[sample.fields.bin]++;
        @(negedge clk);
        sampleValid = 1'b0;
        // -1 in the trace means no window yet
        if (expFlag < 0) begin
            checkFlag(1'b0, 1'b0);
        end else begin
            checkFlag(expFlag[0], 1'b1);
        end
        @(negedge clk);
        // single-cycle flag
        if (flagValid !== 1'b0) begin
            reportMismatch("flagValid", 0, int'(flagValid));
        end
        @(negedge clk);
    endtask

    // scanner holds the RAM until both banks are cleared
    task automatic waitSweepDone();
        int n;
        n = 0;
        while (dut.scanReq !== 1'b0 && n < SWEEP_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (dut.scanReq !== 1'b0) begin
            $display("timeout: RAM clear sweep after reset did not finish in %0d cycles",
                     SWEEP_TIMEOUT);
            timeouts++;
        end
    endtask

    task automatic waitWindow();
        int n;
        n = 0;
        while (algebraicReady !== 1'b1 && n < WINDOW_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (algebraicReady !== 1'b1) begin
            $display("timeout: no algebraicReady within %0d cycles after the frame",
                     WINDOW_TIMEOUT);
            timeouts++;
        end else begin
            gotMinus = thMinus;
            gotPlus  = thPlus;
        end
    endtask

    // trace window against the clamp rule applied to the frame's bin counts
    task automatic ruleCheck(input pixVal_t expMinus, input pixVal_t expPlus);
        int best;
        int centre;
        int lo;
        int hi;
        best = 0;
        for (int i = 1; i < `NBINS; i++) begin
            // lowest bin wins a tie
            if (binTally[i] > binTally[best]) begin
                best = i;
            end
        end
        centre = best * (1 << (`NP - `NB)) + (1 << (`NP - `NB - 1));
        if (centre <= `MARGIN) begin
            lo = 0;
            hi = 2 * `MARGIN;
        end else if (centre >= (1 << `NP) - 1 - `MARGIN) begin
            hi = (1 << `NP) - 1;
            lo = hi - 2 * `MARGIN;
        end else begin
            lo = centre - `MARGIN;
            hi = centre + `MARGIN;
        end
        if (lo != int'(expMinus) || hi != int'(expPlus)) begin
            errors++;
            $display("trace expects window %0d..%0d but bin %0d gives %0d..%0d",
                     expMinus, expPlus, best, lo, hi);
        end
        foreach (binTally[i]) begin
            binTally[i] = 0;
        end
    endtask

    initial begin
        int               fd;
        int               code;
        int               a;
        int               b;
        bit               traceDone;
        logic [7:0]       kind;
        logic [8*128-1:0] lineBuf;

        reset       = 1'b1;
        sampleValid = 1'b0;
        sample      = '0;
        errors      = 0;
        timeouts    = 0;
        checks      = 0;
        gotMinus    = '0;
        gotPlus     = '0;
        traceDone   = 1'b0;
        foreach (binTally[i]) begin
            binTally[i] = 0;
        end

        fd = $fopen("verif/sifh_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file verif/sifh_trace.txt");
            errors++;
            traceDone = 1'b1;
        end

        // reset across 3 rising edges
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        waitSweepDone();

        while (!traceDone && timeouts == 0) begin
            code = $fscanf(fd, "%s", kind);
            if (code != 1) begin
                traceDone = 1'b1;
            end else if (kind == "#") begin
                code = $fgets(lineBuf, fd);
            end else if (kind == "S") begin
                code = $fscanf(fd, "%d %d", a, b);
                if (code == 2) begin
                    driveSample(pixVal_t'(a), b);
                end else begin
                    $display("malformed sample line in the trace file");
                    errors++;
                    traceDone = 1'b1;
                end
            end else if (kind == "G") begin
                code = $fscanf(fd, "%d", a);
                waitWindow();
                if (timeouts == 0) begin
                    repeat (a) @(negedge clk);
                end
            end else if (kind == "T") begin
                code = $fscanf(fd, "%d %d", a, b);
                checkWindow(pixVal_t'(a), pixVal_t'(b), gotMinus, gotPlus);
                ruleCheck(pixVal_t'(a), pixVal_t'(b));
            end else begin
                $display("unknown line kind in the trace file");
                errors++;
                traceDone = 1'b1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        if (checks == 0) begin
            $display("no checks were run");
            errors++;
        end
        $display("errors=%0d timeouts=%0d checks=%0d", errors, timeouts, checks);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== rtl/sifhTop.sv ====
`timescale 1ns/1ps

module sifhTop import sifhPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        sampleValid,
    input  sampleWord_u sample,
    output pixVal_t     thMinus,
    output pixVal_t     thPlus,
    output logic        algebraicReady,
    output logic        flagValid,
    output logic        inWindow,
    output logic        windowValid
);

    // accumulator side of the RAM port
    logic     accReq;
    logic     accWe;
    ramAddr_t accAddr;
    binCnt_t  accWdata;
    logic     accGrant;
    logic     accRvalid;
    // scanner side of the RAM port
    logic     scanReq;
    logic     scanWe;
    ramAddr_t scanAddr;
    binCnt_t  scanWdata;
    logic     scanGrant;
    logic     scanRvalid;
    // shared read data
    binCnt_t  rdata;
    logic     frameDone;
    logic     doneBank;
    logic     peakDone;
    binIdx_t  peakBin;

    histMemArbiter arbiter (
        .clk(clk), .reset(reset),
        .accReq(accReq), .accWe(accWe), .accAddr(accAddr), .accWdata(accWdata),
        .accGrant(accGrant), .accRvalid(accRvalid),
        .scanReq(scanReq), .scanWe(scanWe), .scanAddr(scanAddr), .scanWdata(scanWdata),
        .scanGrant(scanGrant), .scanRvalid(scanRvalid),
        .rdata(rdata)
    );

    // fill side, one bin increment per sample
    histAccumulator accumulator (
        .clk(clk), .reset(reset),
        .sampleValid(sampleValid), .sample(sample),
        .memReq(accReq), .memWe(accWe), .memAddr(accAddr), .memWdata(accWdata),
        .memGrant(accGrant), .memRvalid(accRvalid), .rdata(rdata),
        .frameDone(frameDone), .doneBank(doneBank)
    );

    // also clears both banks for 2*NBINS grants after reset
    peakScanner scanner (
        .clk(clk), .reset(reset),
        .frameDone(frameDone), .doneBank(doneBank),
        .memReq(scanReq), .memWe(scanWe), .memAddr(scanAddr), .memWdata(scanWdata),
        .memGrant(scanGrant), .memRvalid(scanRvalid), .rdata(rdata),
        .peakDone(peakDone), .peakBin(peakBin)
    );

    algebraicBlock algebra (
        .clk(clk), .reset(reset),
        .peakBin(peakBin), .peakDone(peakDone),
        .thMinus(thMinus), .thPlus(thPlus), .algebraicReady(algebraicReady)
    );

    // flags land one cycle after each strobe
    windowClassifier classifier (
        .clk(clk), .reset(reset),
        .sampleValid(sampleValid), .sample(sample),
        .thMinus(thMinus), .thPlus(thPlus), .algebraicReady(algebraicReady),
        .flagValid(flagValid), .inWindow(inWindow), .windowValid(windowValid)
    );

endmodule

// ==== rtl/windowClassifier.sv ====
`timescale 1ns/1ps

module windowClassifier import sifhPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        sampleValid,
    input  sampleWord_u sample,
    input  pixVal_t     thMinus,
    input  pixVal_t     thPlus,
    input  logic        algebraicReady,
    output logic        flagValid,
    output logic        inWindow,
    output logic        windowValid
);

    // copy of the most recent window
    pixVal_t winMinus;
    pixVal_t winPlus;

    always_ff @(posedge clk) begin
        if (reset) begin
            flagValid   <= 1'b0;
            inWindow    <= 1'b0;
            windowValid <= 1'b0;
        end else begin
            flagValid <= sampleValid;
            // inclusive on both edges, 0 until a window exists
            inWindow  <= sampleValid && windowValid &&
                         (sample.value >= winMinus) && (sample.value <= winPlus);
            if (algebraicReady) begin
                windowValid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (algebraicReady) begin
            winMinus <= thMinus;
            winPlus  <= thPlus;
        end
    end

    // a window from upstream is never inverted
    assert property (@(posedge clk) disable iff (reset) algebraicReady |-> thMinus <= thPlus)
        else $error("inverted window");

endmodule

// ==== rtl/algebraicBlock.sv ====
`timescale 1ns/1ps
`include "sifh_params.svh"

module algebraicBlock import sifhPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  binIdx_t peakBin,
    input  logic    peakDone,
    output pixVal_t thMinus,
    output pixVal_t thPlus,
    output logic    algebraicReady
);

    // half a bin width moves the centre into the middle of the bin
    localparam pixVal_t HALF_BIN = pixVal_t'(1 << (`NP - `NB - 1));
    localparam pixVal_t MARGIN_V = pixVal_t'(`MARGIN);
    localparam pixVal_t MAX_V    = '1;

    pixVal_t centre;
    pixVal_t lowEdge;
    pixVal_t highEdge;

    assign centre = {peakBin, {(`NP - `NB){1'b0}}} + HALF_BIN;

    // window keeps its full width at both ends of the range
    always_comb begin
        if (centre <= MARGIN_V) begin
            lowEdge  = '0;
            highEdge = MARGIN_V + MARGIN_V;
        end else if (centre >= MAX_V - MARGIN_V) begin
            highEdge = MAX_V;
            lowEdge  = MAX_V - MARGIN_V - MARGIN_V;
        end else begin
            lowEdge  = centre - MARGIN_V;
            highEdge = centre + MARGIN_V;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            algebraicReady <= 1'b0;
        end else begin
            algebraicReady <= peakDone;
        end
    end

    always_ff @(posedge clk) begin
        if (peakDone) begin
            thMinus <= lowEdge;
            thPlus  <= highEdge;
        end
    end

    // scanner end marker is a single-cycle pulse
    assert property (@(posedge clk) disable iff (reset) peakDone |=> !peakDone)
        else $error("peakDone longer than one cycle");

endmodule

// ==== rtl/peakScanner.sv ====
`timescale 1ns/1ps

module peakScanner import sifhPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     frameDone,
    input  logic     doneBank,
    output logic     memReq,
    output logic     memWe,
    output ramAddr_t memAddr,
    output binCnt_t  memWdata,
    input  logic     memGrant,
    input  logic     memRvalid,
    input  binCnt_t  rdata,
    output logic     peakDone,
    output binIdx_t  peakBin
);

    // fsm encoding, sweep clears both banks once after reset
    localparam logic [2:0] SWEEP = 3'd0;
    localparam logic [2:0] IDLE  = 3'd1;
    localparam logic [2:0] READ  = 3'd2;
    localparam logic [2:0] WAIT  = 3'd3;
    localparam logic [2:0] WRITE = 3'd4;

    logic [2:0] state;
    ramAddr_t   sweepAddr;
    binIdx_t    binIdx;
    // running maximum and where it was seen
    binCnt_t    maxCnt;
    binIdx_t    bestBin;

    // doneBank stays put for the whole scan
    always_comb begin
        memReq   = 1'b0;
        memWe    = 1'b0;
        memAddr  = {doneBank, binIdx};
        memWdata = '0;
        case (state)
            SWEEP: begin
                memReq  = 1'b1;
                memWe   = 1'b1;
                memAddr = sweepAddr;
            end
            READ: begin
                memReq = 1'b1;
            end
            // clear behind the read
            WRITE: begin
                memReq = 1'b1;
                memWe  = 1'b1;
            end
            default: begin
                memReq = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= SWEEP;
            sweepAddr <= '0;
            peakDone  <= 1'b0;
        end else begin
            peakDone <= 1'b0;
            case (state)
                SWEEP: begin
                    if (memGrant) begin
                        sweepAddr <= sweepAddr + 1'b1;
                        if (sweepAddr == '1) begin
                            state <= IDLE;
                        end
                    end
                end
                IDLE: begin
                    if (frameDone) begin
                        state <= READ;
                    end
                end
                READ: begin
                    if (memGrant) begin
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    if (memRvalid) begin
                        state <= WRITE;
                    end
                end
                default: begin
                    if (memGrant) begin
                        if (binIdx == '1) begin
                            state    <= IDLE;
                            peakDone <= 1'b1;
                        end else begin
                            state <= READ;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && frameDone) begin
            binIdx  <= '0;
            maxCnt  <= '0;
            bestBin <= '0;
        end
        // strictly greater, so a tie keeps the lower bin
        if (state == WAIT && memRvalid && rdata > maxCnt) begin
            maxCnt  <= rdata;
            bestBin <= binIdx;
        end
        if (state == WRITE && memGrant) begin
            binIdx <= binIdx + 1'b1;
            if (binIdx == '1) begin
                peakBin <= bestBin;
            end
        end
    end

    // next frame must not finish before this scan does
    assert property (@(posedge clk) disable iff (reset) frameDone |-> state == IDLE)
        else $error("frameDone during scan");

endmodule

// ==== rtl/histAccumulator.sv ====
`timescale 1ns/1ps
`include "sifh_params.svh"

module histAccumulator import sifhPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        sampleValid,
    input  sampleWord_u sample,
    output logic        memReq,
    output logic        memWe,
    output ramAddr_t    memAddr,
    output binCnt_t     memWdata,
    input  logic        memGrant,
    input  logic        memRvalid,
    input  binCnt_t     rdata,
    output logic        frameDone,
    output logic        doneBank
);

    localparam int unsigned FCW = $clog2(`FRAME_LEN);

    // fsm encoding
    localparam logic [1:0] IDLE  = 2'd0;
    localparam logic [1:0] READ  = 2'd1;
    localparam logic [1:0] WAIT  = 2'd2;
    localparam logic [1:0] WRITE = 2'd3;

    logic [1:0]     state;
    // bank currently being filled
    logic           fillBank;
    binIdx_t        binReg;
    // incremented count waiting for its write slot
    binCnt_t        wrCnt;
    logic [FCW-1:0] frameCnt;

    always_comb begin
        memReq   = 1'b0;
        memWe    = 1'b0;
        memAddr  = {fillBank, binReg};
        memWdata = wrCnt;
        case (state)
            // read straight off the strobe, saves a cycle
            IDLE: begin
                memReq  = sampleValid;
                memAddr = {fillBank, sample.fields.bin};
            end
            READ: begin
                memReq = 1'b1;
            end
            WRITE: begin
                memReq = 1'b1;
                memWe  = 1'b1;
            end
            default: begin
                memReq = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            fillBank  <= 1'b0;
            frameCnt  <= '0;
            frameDone <= 1'b0;
            doneBank  <= 1'b0;
        end else begin
            frameDone <= 1'b0;
            case (state)
                IDLE: begin
                    if (sampleValid) begin
                        state <= memGrant ? WAIT : READ;
                    end
                end
                READ: begin
                    if (memGrant) begin
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    if (memRvalid) begin
                        state <= WRITE;
                    end
                end
                default: begin
                    if (memGrant) begin
                        state <= IDLE;
                        // last write of the frame, hand the bank over
                        if (frameCnt == FCW'(`FRAME_LEN - 1)) begin
                            frameCnt  <= '0;
                            frameDone <= 1'b1;
                            doneBank  <= fillBank;
                            fillBank  <= ~fillBank;
                        end else begin
                            frameCnt <= frameCnt + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && sampleValid) begin
            binReg <= sample.fields.bin;
        end
        // saturate at counter max
        if (state == WAIT && memRvalid) begin
            wrCnt <= (rdata == '1) ? rdata : rdata + 1'b1;
        end
    end

    // source keeps samples at least 4 cycles apart
    assert property (@(posedge clk) disable iff (reset) sampleValid |-> state == IDLE)
        else $error("sample arrived while accumulator busy");

endmodule

// ==== rtl/histMemArbiter.sv ====
`timescale 1ns/1ps

module histMemArbiter import sifhPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     accReq,
    input  logic     accWe,
    input  ramAddr_t accAddr,
    input  binCnt_t  accWdata,
    output logic     accGrant,
    output logic     accRvalid,
    input  logic     scanReq,
    input  logic     scanWe,
    input  ramAddr_t scanAddr,
    input  binCnt_t  scanWdata,
    output logic     scanGrant,
    output logic     scanRvalid,
    output binCnt_t  rdata
);

    // when 0 the accumulator wins a clash
    logic     rrPtr;
    // a read went to the RAM last cycle
    logic     rdPending;
    // who issued that read
    logic     rdOwnerScan;
    logic     ramWe;
    ramAddr_t ramAddr;
    binCnt_t  ramWdata;

    // a lone requester always wins
    assign accGrant  = accReq && (!scanReq || !rrPtr);
    assign scanGrant = scanReq && (!accReq || rrPtr);

    // forward the winner to the RAM
    always_comb begin
        if (scanGrant) begin
            ramWe    = scanWe;
            ramAddr  = scanAddr;
            ramWdata = scanWdata;
        end else begin
            ramWe    = accGrant && accWe;
            ramAddr  = accAddr;
            ramWdata = accWdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rrPtr       <= 1'b0;
            rdPending   <= 1'b0;
            rdOwnerScan <= 1'b0;
        end else begin
            // flip only when both wanted the port
            if (accReq && scanReq) begin
                rrPtr <= ~rrPtr;
            end
            rdPending   <= (accGrant && !accWe) || (scanGrant && !scanWe);
            rdOwnerScan <= scanGrant;
        end
    end

    // read data lands one cycle after the grant
    assign accRvalid  = rdPending && !rdOwnerScan;
    assign scanRvalid = rdPending && rdOwnerScan;

    histRam ram (
        .clk  (clk),
        .we   (ramWe),
        .addr (ramAddr),
        .wdata(ramWdata),
        .rdata(rdata)
    );

    // one owner of the port per cycle
    assert property (@(posedge clk) disable iff (reset) !(accGrant && scanGrant))
        else $error("both RAM grants high");

    // a waiting accumulator keeps its request and wins the next cycle
    assert property (@(posedge clk) disable iff (reset)
        (accReq && !accGrant) |=> accGrant)
        else $error("accumulator not granted after waiting");

endmodule

// ==== rtl/histRam.sv ====
`timescale 1ns/1ps
`include "sifh_params.svh"

module histRam import sifhPkg::*; (
    input  logic     clk,
    input  logic     we,
    input  ramAddr_t addr,
    input  binCnt_t  wdata,
    output binCnt_t  rdata
);

    // both banks in one array, bank bit is the address msb
    binCnt_t mem [2 * `NBINS];

    // single port
    // a write cycle still returns the old word on rdata
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// ==== rtl/sifhPkg.sv ====
`include "sifh_params.svh"

package sifhPkg;

    // histogram bin number
    typedef logic [`NB - 1 : 0] binIdx_t;

    // count held in one bin
    typedef logic [`CNT_W - 1 : 0] binCnt_t;

    // sample or threshold value
    typedef logic [`NP - 1 : 0] pixVal_t;

    // bank select bit on top of the bin number
    typedef logic [`NB : 0] ramAddr_t;

    // bin on top, position inside the bin below
    typedef struct packed {
        binIdx_t                  bin;
        logic [`NP - `NB - 1 : 0] frac;
    } sampleFields_t;

    // one sample word, seen whole or split
    typedef union packed {
        pixVal_t       value;
        sampleFields_t fields;
    } sampleWord_u;

endpackage

// ==== rtl/sifh_params.svh ====
`ifndef SIFH_PARAMS_SVH
`define SIFH_PARAMS_SVH

// bin index width, taken from the top of a sample
`define NB 4

// sample and threshold width
`define NP 8

// samples accumulated before a bank is scanned
`define FRAME_LEN 8

// bins in one bank
`define NBINS (1 << `NB)

// per-bin counter width, saturating
`define CNT_W 8

// half-span of the acceptance window
`define MARGIN ((1 << (`NB - 1)) + (1 << (`NB - 2)))

`endif
